/* Makefile */
# Verilator build and run for the DLL receive testbench

VERILATOR ?= verilator
TOP       ?= tb_dll_rx
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/dll_rx_assertions.sv */
// concurrent checks bound into the DLL receive top level
// flow control handshake, input back-pressure, output stability
`timescale 1ns/1ps
`default_nettype none

module dll_rx_assertions
  import dll_rx_pkg::*;
(
  input logic   clk_i,
  input logic   rst_i,
  input logic   fc_req_o,
  input logic   fc_ack_i,
  input logic   s_tready_o,
  input dword_t m_tdata_o,
  input logic   m_tvalid_o,
  input logic   m_tlast_o,
  input logic   m_tready_i
);

  // number of failed assertions
  int fail_count = 0;

  req_rise_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(fc_req_o) |-> !$past(fc_ack_i))
    else begin
      fail_count++;
      $error("fc_req_o rose while fc_ack_i was high");
    end

  req_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    fc_req_o && !fc_ack_i |=> fc_req_o)
    else begin
      fail_count++;
      $error("fc_req_o fell before fc_ack_i");
    end

  // no input beats during the handshake
  ready_low_a: assert property (@(posedge clk_i) disable iff (rst_i)
    fc_req_o |-> !s_tready_o)
    else begin
      fail_count++;
      $error("s_tready_o high while fc_req_o is high");
    end

  out_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) && $stable(m_tlast_o))
    else begin
      fail_count++;
      $error("output stream changed while stalled");
    end

endmodule

bind dll_rx_top dll_rx_assertions u_assertions (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .fc_req_o   (fc_req_o),
  .fc_ack_i   (fc_ack_i),
  .s_tready_o (s_tready_o),
  .m_tdata_o  (m_tdata_o),
  .m_tvalid_o (m_tvalid_o),
  .m_tlast_o  (m_tlast_o),
  .m_tready_i (m_tready_i)
);

`default_nettype wire

/* bench/tb_dll_rx.sv */
// testbench for the DLL receive path
// LFSR stimulus, reference model, flow control responder
// output stream and status checks with per-test reporting
`timescale 1ns/1ps
`default_nettype none

module tb_dll_rx;
  import dll_rx_pkg::*;

  localparam int BEAT_LIMIT  = 1000;
  localparam int REQ_LIMIT   = 200;
  localparam int DRAIN_LIMIT = 5000;

  logic         clk_i = 1'b0;
  logic         rst_i;
  logic         link_active_i;
  dword_t       s_tdata_i;
  logic         s_tvalid_i;
  logic         s_tlast_i;
  logic         s_tready_o;
  dword_t       m_tdata_o;
  logic         m_tvalid_o;
  logic         m_tlast_o;
  logic         m_tready_i = 1'b1;
  logic         fc_req_o;
  logic         fc_ack_i = 1'b0;
  logic         tlp_nullified_o;
  seq_t         rx_seq_o;
  seq_t         expected_seq_o;
  hdr_credit_t  ph_credits_o;
  hdr_credit_t  nph_credits_o;
  data_credit_t pd_credits_o;
  data_credit_t npd_credits_o;

  // model state
  seq_t         m_exp_seq = '0;
  seq_t         m_rx_seq = '0;
  logic         m_nullified = 1'b0;
  hdr_credit_t  m_ph = '0;
  hdr_credit_t  m_nph = '0;
  data_credit_t m_pd = '0;
  data_credit_t m_npd = '0;
  dword_t       exp_q [$];
  logic         last_q [$];

  int          errors = 0;
  int          err_mark = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        rdy_random = 1'b0;
  logic        ack_pending = 1'b0;
  int          ack_delay = 0;
  // one LFSR per random stream
  logic [15:0] stim_lfsr = 16'd45643;
  logic [15:0] rdy_lfsr = 16'd45643;
  logic [15:0] ack_lfsr = 16'd45643;

  // last entry is not a known opcode
  logic [7:0] op_list [13] = '{MRd3, MRd4, IORd, CfgRd0, MWr3, MWr4, IOWr, CfgWr0,
                               Msg, MsgD, Cpl, CplD, 8'h7F};

  dll_rx_top #(
    .FIFO_DEPTH (512)
  ) u_dll_rx_top (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .link_active_i   (link_active_i),
    .s_tdata_i       (s_tdata_i),
    .s_tvalid_i      (s_tvalid_i),
    .s_tlast_i       (s_tlast_i),
    .s_tready_o      (s_tready_o),
    .m_tdata_o       (m_tdata_o),
    .m_tvalid_o      (m_tvalid_o),
    .m_tlast_o       (m_tlast_o),
    .m_tready_i      (m_tready_i),
    .fc_req_o        (fc_req_o),
    .fc_ack_i        (fc_ack_i),
    .tlp_nullified_o (tlp_nullified_o),
    .rx_seq_o        (rx_seq_o),
    .expected_seq_o  (expected_seq_o),
    .ph_credits_o    (ph_credits_o),
    .nph_credits_o   (nph_credits_o),
    .pd_credits_o    (pd_credits_o),
    .npd_credits_o   (npd_credits_o)
  );

  always #2 clk_i = ~clk_i;

  // fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n, inout logic [15:0] st);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = st[15] ^ st[13] ^ st[12] ^ st[10];
      st = {st[14:0], fb};
      v  = {v[30:0], fb};
    end
    return v;
  endfunction

  // reflected CRC-32 over one byte
  function automatic crc_t crc_byte(input crc_t c, input logic [7:0] b);
    crc_t r;
    r = c ^ {24'h0, b};
    for (int k = 0; k < 8; k++) begin
      r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
    end
    return r;
  endfunction

  function automatic logic has_payload(input logic [7:0] op);
    return (op == MWr3) || (op == MWr4) || (op == IOWr) || (op == CfgWr0) ||
           (op == MsgD) || (op == CplD);
  endfunction

  task automatic check_word(input dword_t got, input dword_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic check_seq(input seq_t got, input seq_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %03h, expected %03h", $time, what, got, exp);
    end
  endtask

  task automatic check_hdr_credit(input hdr_credit_t got, input hdr_credit_t exp,
                                  input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_data_credit(input data_credit_t got, input data_credit_t exp,
                                   input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_credits();
    check_hdr_credit(ph_credits_o, m_ph, "ph_credits_o");
    check_hdr_credit(nph_credits_o, m_nph, "nph_credits_o");
    check_data_credit(pd_credits_o, m_pd, "pd_credits_o");
    check_data_credit(npd_credits_o, m_npd, "npd_credits_o");
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_mark) begin
      tests_failed++;
      $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - err_mark);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    err_mark = errors;
  endtask

  // ready is sampled mid-cycle and the beat is taken at the next rising edge
  task automatic send_beat(input dword_t data, input logic last);
    int   n;
    logic taken;
    s_tdata_i  = data;
    s_tvalid_i = 1'b1;
    s_tlast_i  = last;
    n = 0;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = s_tready_o;
      @(posedge clk_i);
      #1;
      n++;
      if (!taken && n > BEAT_LIMIT) abort_on_timeout("s_tready_o");
    end
  endtask

  task automatic wait_for_req(input logic level);
    int n;
    n = 0;
    @(negedge clk_i);
    while (fc_req_o !== level) begin
      n++;
      if (n > REQ_LIMIT) abort_on_timeout("fc_req_o");
      @(negedge clk_i);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      n++;
      if (n > DRAIN_LIMIT) abort_on_timeout("the output stream to drain");
    end
    @(posedge clk_i);
    #1;
  endtask

  // fault 0 is a good frame, 1 a flipped LCRC bit and 2 a wrong sequence number
  task automatic run_frame(input logic [7:0] op, input int fault);
    dword_t       tlp [$];
    seq_t         seq;
    crc_t         c;
    logic [9:0]   len;
    int           len_dw;
    int           n_hdr;
    int           n_data;
    data_credit_t dc;
    logic         good;
    good = (fault == 0);
    len  = 10'(rand_bits(4, stim_lfsr));
    seq  = (fault == 2) ? m_exp_seq + 12'd1 + 12'(rand_bits(3, stim_lfsr)) : m_exp_seq;
    n_hdr  = ((op == MRd4) || (op == MWr4)) ? 4 : 3;
    // payload trimmed to 8 dwords for a zero length field
    n_data = has_payload(op) ? ((len == 10'd0) ? 8 : int'(len)) : 0;
    tlp.push_back({len[7:0], 6'(rand_bits(6, stim_lfsr)), len[9:8],
                   8'(rand_bits(8, stim_lfsr)), op});
    for (int i = 1; i < n_hdr + n_data; i++) begin
      tlp.push_back(rand_bits(32, stim_lfsr));
    end
    c = 32'hFFFF_FFFF;
    c = crc_byte(c, seq[7:0]);
    c = crc_byte(c, {4'h0, seq[11:8]});
    foreach (tlp[i]) begin
      for (int b = 0; b < 4; b++) begin
        c = crc_byte(c, tlp[i][8*b +: 8]);
      end
    end
    c = ~c;
    if (fault == 1) c = c ^ (32'h1 << rand_bits(5, stim_lfsr));
    m_rx_seq    = seq;
    m_nullified = !good;
    if (good) begin
      foreach (tlp[i]) begin
        exp_q.push_back(tlp[i]);
        last_q.push_back(i == tlp.size() - 1);
      end
      m_exp_seq = m_exp_seq + 12'd1;
      len_dw = (len == 10'd0) ? 1024 : int'(len);
      dc = 12'((len_dw + 3) / 4);
      case (op)
        MRd3, MRd4, IORd, CfgRd0: m_nph = m_nph + 8'd1;
        IOWr, CfgWr0: begin
          m_nph = m_nph + 8'd1;
          m_npd = m_npd + dc;
        end
        MWr3, MWr4, MsgD: begin
          m_ph = m_ph + 8'd1;
          m_pd = m_pd + dc;
        end
        Msg:     m_ph = m_ph + 8'd1;
        default: ;
      endcase
    end
    // bits above the sequence number carry random junk
    send_beat({20'(rand_bits(20, stim_lfsr)), seq}, 1'b0);
    foreach (tlp[i]) send_beat(tlp[i], 1'b0);
    send_beat(c, 1'b1);
    s_tvalid_i = 1'b0;
    s_tlast_i  = 1'b0;
    // status is updated by the time fc_req_o rises
    wait_for_req(1'b1);
    check_flag(tlp_nullified_o, m_nullified, "tlp_nullified_o");
    check_seq(rx_seq_o, m_rx_seq, "rx_seq_o");
    check_seq(expected_seq_o, m_exp_seq, "expected_seq_o");
    check_credits();
    wait_for_req(1'b0);
    @(posedge clk_i);
    #1;
  endtask

  function automatic logic [7:0] random_op();
    return op_list[int'(rand_bits(4, stim_lfsr)) % 13];
  endfunction

  // transfer seen mid-cycle completes at the next rising edge
  task automatic watch_output();
    forever begin
      @(negedge clk_i);
      if (!rst_i && m_tvalid_o && m_tready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected output word %08h at %0t ns", m_tdata_o, $time);
        end else begin
          check_word(m_tdata_o, exp_q.pop_front(), "m_tdata_o");
          check_flag(m_tlast_o, last_q.pop_front(), "m_tlast_o");
        end
      end
    end
  endtask

  always @(posedge clk_i) begin
    #1;
    m_tready_i = rdy_random ? (rand_bits(2, rdy_lfsr) != 32'd0) : 1'b1;
  end

  // flow control responder acks after a random delay
  always @(posedge clk_i) begin
    #1;
    if (rst_i) begin
      fc_ack_i    = 1'b0;
      ack_pending = 1'b0;
    end else if (fc_ack_i) begin
      if (!fc_req_o) fc_ack_i = 1'b0;
    end else if (fc_req_o) begin
      if (!ack_pending) begin
        ack_pending = 1'b1;
        ack_delay   = int'(rand_bits(3, ack_lfsr));
      end else if (ack_delay == 0) begin
        fc_ack_i    = 1'b1;
        ack_pending = 1'b0;
      end else begin
        ack_delay--;
      end
    end
  end

  initial begin
    int f;
    int assert_fails;
    rst_i         = 1'b1;
    link_active_i = 1'b0;
    s_tdata_i     = '0;
    s_tvalid_i    = 1'b0;
    s_tlast_i     = 1'b0;
    fork
      watch_output();
    join_none
    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    @(negedge clk_i);
    check_flag(s_tready_o, 1'b0, "s_tready_o");
    check_flag(m_tvalid_o, 1'b0, "m_tvalid_o");
    check_flag(fc_req_o, 1'b0, "fc_req_o");
    check_flag(tlp_nullified_o, 1'b0, "tlp_nullified_o");
    check_seq(expected_seq_o, 12'd0, "expected_seq_o");
    check_credits();
    @(posedge clk_i);
    #1;
    link_active_i = 1'b1;
    end_test("reset values");

    for (int i = 0; i < 12; i++) run_frame(op_list[i], 0);
    wait_drain();
    end_test("every opcode");

    for (int i = 0; i < 4; i++) begin
      run_frame(random_op(), 1);
      run_frame(random_op(), 0);
    end
    wait_drain();
    end_test("LCRC error drop");

    for (int i = 0; i < 4; i++) begin
      run_frame(random_op(), 2);
      run_frame(random_op(), 0);
    end
    wait_drain();
    end_test("sequence error drop");

    for (int i = 0; i < 30; i++) run_frame(random_op(), 0);
    wait_drain();
    end_test("credit sums");

    rdy_random = 1'b1;
    for (int i = 0; i < 40; i++) begin
      f = int'(rand_bits(3, stim_lfsr));
      run_frame(random_op(), (f == 0) ? 1 : ((f == 1) ? 2 : 0));
    end
    wait_drain();
    rdy_random = 1'b0;
    end_test("random back-pressure");

    // a waiting sequence beat must not be taken while the link is down
    link_active_i = 1'b0;
    s_tdata_i     = {20'h0, m_exp_seq};
    s_tvalid_i    = 1'b1;
    repeat (20) begin
      @(negedge clk_i);
      check_flag(s_tready_o, 1'b0, "s_tready_o");
      check_flag(m_tvalid_o, 1'b0, "m_tvalid_o");
      check_flag(fc_req_o, 1'b0, "fc_req_o");
      check_flag(tlp_nullified_o, m_nullified, "tlp_nullified_o");
      check_seq(rx_seq_o, m_rx_seq, "rx_seq_o");
      check_seq(expected_seq_o, m_exp_seq, "expected_seq_o");
      check_credits();
    end
    @(posedge clk_i);
    #1;
    s_tvalid_i    = 1'b0;
    link_active_i = 1'b1;
    run_frame(random_op(), 0);
    wait_drain();
    end_test("link inactive");

    assert_fails = u_dll_rx_top.u_assertions.fail_count;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, assert_fails);
    if ((errors == 0) && (assert_fails == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* common/dll_rx_pkg.sv */
// shared types for the PCIe DLL receive path
// TLP opcode and credit kind enums, LCRC constants
// header classification function
`default_nettype none

package dll_rx_pkg;

  typedef logic [31:0] dword_t;
  typedef logic [11:0] seq_t;
  typedef logic [7:0]  hdr_credit_t;
  // one data credit per 4 dwords
  typedef logic [11:0] data_credit_t;
  typedef logic [31:0] crc_t;

  // reflected form of 0x04C11DB7
  localparam crc_t LCRC_POLY = 32'hEDB8_8320;
  localparam crc_t LCRC_INIT = 32'hFFFF_FFFF;

  // header byte 0, fmt and type together
  typedef enum logic [7:0] {
    MRd3   = 8'h00,
    MRd4   = 8'h20,
    IORd   = 8'h02,
    CfgRd0 = 8'h04,
    MWr3   = 8'h40,
    MWr4   = 8'h60,
    IOWr   = 8'h42,
    CfgWr0 = 8'h44,
    Msg    = 8'h30,
    MsgD   = 8'h70,
    Cpl    = 8'h0A,
    CplD   = 8'h4A
  } tlp_type_e;

  typedef enum logic [2:0] {
    KIND_PH,
    KIND_PD,
    KIND_NPH,
    KIND_NPD,
    KIND_CPL,
    KIND_CPLD,
    KIND_NONE
  } tlp_kind_e;

  // credit class of a TLP from its first header byte
  function automatic tlp_kind_e tlp_kind_of(input logic [7:0] byte0);
    tlp_kind_e kind;
    case (byte0)
      MRd3, MRd4, IORd, CfgRd0: kind = KIND_NPH;
      IOWr, CfgWr0:             kind = KIND_NPD;
      MWr3, MWr4, MsgD:         kind = KIND_PD;
      Msg:                      kind = KIND_PH;
      Cpl:                      kind = KIND_CPL;
      CplD:                     kind = KIND_CPLD;
      default:                  kind = KIND_NONE;
    endcase
    return kind;
  endfunction

endpackage

`default_nettype wire

/* common/frame_wr_if.sv */
// write side of the frame FIFO
// TLP dwords plus commit and drop of the pending frame
`timescale 1ns/1ps
`default_nettype none

interface frame_wr_if
  import dll_rx_pkg::*;
();

  logic   wr_valid;
  dword_t wr_data;
  // space for one more word
  logic   wr_ready;
  // single cycle pulses, never together
  logic   commit;
  logic   drop;

  modport src (
    output wr_valid,
    output wr_data,
    output commit,
    output drop,
    input  wr_ready
  );

  modport snk (
    input  wr_valid,
    input  wr_data,
    input  commit,
    input  drop,
    output wr_ready
  );

endinterface

`default_nettype wire

/* frame_fifo/frame_fifo.sv */
// frame FIFO with tentative write pointer
// commit publishes the pending frame, drop rewinds it
`timescale 1ns/1ps
`default_nettype none

module frame_fifo
  import dll_rx_pkg::*;
#(
  // power of two
  parameter int FIFO_DEPTH = 512
) (
  input  logic    clk_i,
  input  logic    rst_i,
  frame_wr_if.snk wr,
  output dword_t  m_tdata_o,
  output logic    m_tvalid_o,
  output logic    m_tlast_o,
  input  logic    m_tready_i
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam logic [AW:0] FullCount = (AW + 1)'(FIFO_DEPTH);

  dword_t        mem [FIFO_DEPTH];
  logic          last_mem [FIFO_DEPTH];
  // extra msb tells full from empty
  logic [AW:0]   wr_ptr;
  logic [AW:0]   pub_ptr;
  logic [AW:0]   rd_ptr;
  logic [AW:0]   used;
  logic [AW-1:0] last_addr;
  logic          wr_en;
  logic          rd_en;
  dword_t        out_data_r;
  logic          out_last_r;
  logic          out_valid_r;

  // rd_ptr frees space, so uncommitted words are counted as used
  assign used        = wr_ptr - rd_ptr;
  assign wr.wr_ready = (used != FullCount);
  assign wr_en       = wr.wr_valid && wr.wr_ready;
  assign last_addr   = wr_ptr[AW-1:0] - 1'b1;

  // refill the output register from committed words only
  assign rd_en = (rd_ptr != pub_ptr) && (!out_valid_r || m_tready_i);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]]      <= wr.wr_data;
      last_mem[wr_ptr[AW-1:0]] <= 1'b0;
    end
    // commit never coincides with a write
    if (wr.commit) begin
      last_mem[last_addr] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr  <= '0;
      pub_ptr <= '0;
    end else if (wr.commit) begin
      pub_ptr <= wr_ptr;
    end else if (wr.drop) begin
      wr_ptr <= pub_ptr;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr      <= '0;
      out_valid_r <= 1'b0;
    end else if (rd_en) begin
      rd_ptr      <= rd_ptr + 1'b1;
      out_valid_r <= 1'b1;
    end else if (m_tready_i) begin
      out_valid_r <= 1'b0;
    end
  end

  // held while the sink stalls
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      out_data_r <= mem[rd_ptr[AW-1:0]];
      out_last_r <= last_mem[rd_ptr[AW-1:0]];
    end
  end

  assign m_tdata_o  = out_data_r;
  assign m_tlast_o  = out_last_r;
  assign m_tvalid_o = out_valid_r;

endmodule

`default_nettype wire

/* hdl/credit_tracker.sv */
// TLP header classification
// posted and non-posted header and data credit counters
`timescale 1ns/1ps
`default_nettype none

module credit_tracker
  import dll_rx_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         hdr_valid_i,
  input  dword_t       hdr_i,
  input  logic         commit_i,
  output hdr_credit_t  ph_credits_o,
  output hdr_credit_t  nph_credits_o,
  output data_credit_t pd_credits_o,
  output data_credit_t npd_credits_o
);

  tlp_kind_e    kind_r;
  data_credit_t dcred_r;
  logic [11:0]  len_dw;
  data_credit_t dcred;
  hdr_credit_t  ph_r;
  hdr_credit_t  nph_r;
  data_credit_t pd_r;
  data_credit_t npd_r;

  // length is byte 2 bits 1:0 above byte 3, zero means 1024
  assign len_dw = ({hdr_i[17:16], hdr_i[31:24]} == 10'd0) ? 12'd1024 :
                  {2'b00, hdr_i[17:16], hdr_i[31:24]};
  // round up to whole credits
  assign dcred  = (len_dw + 12'd3) >> 2;

  always_ff @(posedge clk_i) begin
    if (hdr_valid_i) begin
      kind_r  <= tlp_kind_of(hdr_i[7:0]);
      dcred_r <= dcred;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ph_r  <= '0;
      nph_r <= '0;
      pd_r  <= '0;
      npd_r <= '0;
    end else if (commit_i) begin
      case (kind_r)
        KIND_PH: ph_r <= ph_r + 8'd1;
        KIND_PD: begin
          ph_r <= ph_r + 8'd1;
          pd_r <= pd_r + dcred_r;
        end
        KIND_NPH: nph_r <= nph_r + 8'd1;
        KIND_NPD: begin
          nph_r <= nph_r + 8'd1;
          npd_r <= npd_r + dcred_r;
        end
        // completions and unknown types consume nothing here
        default: ;
      endcase
    end
  end

  assign ph_credits_o  = ph_r;
  assign nph_credits_o = nph_r;
  assign pd_credits_o  = pd_r;
  assign npd_credits_o = npd_r;

endmodule

`default_nettype wire

/* hdl/dll_rx_ctrl.sv */
// receive FSM of the data link layer
// sequence capture and check, LCRC verdict, commit or drop
// four-phase handshake with flow control after each frame
`timescale 1ns/1ps
`default_nettype none

module dll_rx_ctrl
  import dll_rx_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       link_active_i,
  input  dword_t     s_tdata_i,
  input  logic       s_tvalid_i,
  input  logic       s_tlast_i,
  output logic       s_tready_o,
  frame_wr_if.src    wr,
  output logic       crc_clear_o,
  output logic       crc_update_o,
  output dword_t     crc_data_o,
  output logic       crc_first_o,
  input  crc_t       crc_i,
  output logic       hdr_valid_o,
  output logic       commit_o,
  output logic       fc_req_o,
  input  logic       fc_ack_i,
  output logic       tlp_nullified_o,
  output seq_t       rx_seq_o,
  output seq_t       expected_seq_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_PAYLOAD,
    ST_CHECK,
    ST_FC_REQ,
    ST_FC_RELEASE
  } rx_state_e;

  rx_state_e state;
  seq_t      seq_r;
  seq_t      rx_seq_r;
  seq_t      expected_seq_r;
  crc_t      lcrc_r;
  logic      fc_req_r;
  logic      nullified_r;
  logic      beat_ok;
  logic      lcrc_beat;
  logic      frame_good;

  // sequence beat needs an active link and stream beats need FIFO space
  always_comb begin
    case (state)
      ST_IDLE:               s_tready_o = link_active_i;
      ST_HEADER, ST_PAYLOAD: s_tready_o = wr.wr_ready;
      default:               s_tready_o = 1'b0;
    endcase
  end

  assign beat_ok   = s_tvalid_i && s_tready_o;
  // tlast in the payload marks the LCRC dword
  assign lcrc_beat = (state == ST_PAYLOAD) && s_tlast_i;

  assign wr.wr_valid = s_tvalid_i && ((state == ST_HEADER) ||
                                      ((state == ST_PAYLOAD) && !s_tlast_i));
  assign wr.wr_data  = s_tdata_i;

  // crc_i is final here since the last TLP dword went in a cycle earlier or more
  assign frame_good = (lcrc_r == crc_i) && (seq_r == expected_seq_r);
  assign wr.commit  = (state == ST_CHECK) && frame_good;
  assign wr.drop    = (state == ST_CHECK) && !frame_good;
  assign commit_o   = wr.commit;

  // crc restarts from its seed on the sequence beat
  // only the 12 sequence bits are folded there as two bytes
  assign crc_clear_o  = (state == ST_IDLE);
  assign crc_first_o  = (state == ST_IDLE);
  assign crc_update_o = beat_ok && !lcrc_beat;
  assign crc_data_o   = crc_first_o ? {20'h0, s_tdata_i[11:0]} : s_tdata_i;
  assign hdr_valid_o  = (state == ST_HEADER) && beat_ok;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state          <= ST_IDLE;
      fc_req_r       <= 1'b0;
      nullified_r    <= 1'b0;
      rx_seq_r       <= '0;
      expected_seq_r <= '0;
    end else begin
      case (state)
        ST_IDLE: if (beat_ok) state <= ST_HEADER;
        ST_HEADER: if (beat_ok) state <= ST_PAYLOAD;
        ST_PAYLOAD: if (beat_ok && s_tlast_i) state <= ST_CHECK;
        ST_CHECK: begin
          nullified_r <= !frame_good;
          rx_seq_r    <= seq_r;
          if (frame_good) begin
            expected_seq_r <= expected_seq_r + 12'd1;
          end
          // ack already seen low before this frame started
          fc_req_r <= 1'b1;
          state    <= ST_FC_REQ;
        end
        ST_FC_REQ: begin
          if (fc_ack_i) begin
            fc_req_r <= 1'b0;
            state    <= ST_FC_RELEASE;
          end
        end
        ST_FC_RELEASE: if (!fc_ack_i) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // frame fields
  always_ff @(posedge clk_i) begin
    if ((state == ST_IDLE) && beat_ok) begin
      seq_r <= s_tdata_i[11:0];
    end
    if (lcrc_beat && beat_ok) begin
      lcrc_r <= s_tdata_i;
    end
  end

  assign fc_req_o        = fc_req_r;
  assign tlp_nullified_o = nullified_r;
  assign rx_seq_o        = rx_seq_r;
  assign expected_seq_o  = expected_seq_r;

endmodule

`default_nettype wire

/* hdl/dll_rx_top.sv */
// receive half of the PCIe data link layer
// control FSM, LCRC checker, credit counters and frame FIFO
`timescale 1ns/1ps
`default_nettype none

module dll_rx_top
  import dll_rx_pkg::*;
#(
  // must hold the largest frame, power of two
  parameter int FIFO_DEPTH = 512
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         link_active_i,
  // stream from the physical side
  input  dword_t       s_tdata_i,
  input  logic         s_tvalid_i,
  input  logic         s_tlast_i,
  output logic         s_tready_o,
  // stream to the transaction layer
  output dword_t       m_tdata_o,
  output logic         m_tvalid_o,
  output logic         m_tlast_o,
  input  logic         m_tready_i,
  // flow control handshake
  output logic         fc_req_o,
  input  logic         fc_ack_i,
  // status
  output logic         tlp_nullified_o,
  output seq_t         rx_seq_o,
  output seq_t         expected_seq_o,
  output hdr_credit_t  ph_credits_o,
  output hdr_credit_t  nph_credits_o,
  output data_credit_t pd_credits_o,
  output data_credit_t npd_credits_o
);

  logic   crc_clear;
  logic   crc_update;
  logic   crc_first;
  dword_t crc_data;
  crc_t   crc;
  logic   hdr_valid;
  logic   commit;

  frame_wr_if u_frame_wr ();

  dll_rx_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .link_active_i   (link_active_i),
    .s_tdata_i       (s_tdata_i),
    .s_tvalid_i      (s_tvalid_i),
    .s_tlast_i       (s_tlast_i),
    .s_tready_o      (s_tready_o),
    .wr              (u_frame_wr),
    .crc_clear_o     (crc_clear),
    .crc_update_o    (crc_update),
    .crc_data_o      (crc_data),
    .crc_first_o     (crc_first),
    .crc_i           (crc),
    .hdr_valid_o     (hdr_valid),
    .commit_o        (commit),
    .fc_req_o        (fc_req_o),
    .fc_ack_i        (fc_ack_i),
    .tlp_nullified_o (tlp_nullified_o),
    .rx_seq_o        (rx_seq_o),
    .expected_seq_o  (expected_seq_o)
  );

  lcrc_checker u_lcrc (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .clear_i  (crc_clear),
    .update_i (crc_update),
    .first_i  (crc_first),
    .data_i   (crc_data),
    .crc_o    (crc)
  );

  credit_tracker u_credits (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .hdr_valid_i   (hdr_valid),
    .hdr_i         (s_tdata_i),
    .commit_i      (commit),
    .ph_credits_o  (ph_credits_o),
    .nph_credits_o (nph_credits_o),
    .pd_credits_o  (pd_credits_o),
    .npd_credits_o (npd_credits_o)
  );

  frame_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr         (u_frame_wr),
    .m_tdata_o  (m_tdata_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tlast_o  (m_tlast_o),
    .m_tready_i (m_tready_i)
  );

endmodule

`default_nettype wire

/* hdl/lcrc_checker.sv */
// running LCRC, reflected CRC-32 over seq and TLP bytes
// two bytes on the sequence beat, four on every TLP dword
`timescale 1ns/1ps
`default_nettype none

module lcrc_checker
  import dll_rx_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   clear_i,
  input  logic   update_i,
  input  logic   first_i,
  input  dword_t data_i,
  output crc_t   crc_o
);

  crc_t crc_r;
  crc_t crc_nxt;

  // clear and update in one cycle start a fresh CRC from the seed
  always_comb begin : fold
    crc_t c;
    c = clear_i ? LCRC_INIT : crc_r;
    if (update_i) begin
      for (int b = 0; b < 4; b++) begin
        if ((b < 2) || !first_i) begin
          c = c ^ {24'h0, data_i[8*b +: 8]};
          for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ LCRC_POLY) : (c >> 1);
          end
        end
      end
    end
    crc_nxt = c;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      crc_r <= LCRC_INIT;
    end else begin
      crc_r <= crc_nxt;
    end
  end

  // final complement, compares directly with the received dword
  assign crc_o = ~crc_r;

endmodule

`default_nettype wire

/* project.f */
common/dll_rx_pkg.sv
common/frame_wr_if.sv
hdl/lcrc_checker.sv
hdl/credit_tracker.sv
hdl/dll_rx_ctrl.sv
frame_fifo/frame_fifo.sv
hdl/dll_rx_top.sv
bench/dll_rx_assertions.sv
bench/tb_dll_rx.sv
